// File: bench/ldst_checker.sv
`timescale 1ns/1ps
`default_nettype none

module ldst_checker #(
    parameter int MEM_WORDS = 1024
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            ready,
    input  logic            ren,
    input  logic            wen,
    input  logic            sign,
    input  ldst_pkg::size_e size,
    input  logic [31:0]     addr,
    input  logic [31:0]     wdata,
    input  logic [31:0]     rdata,
    input  logic            valid,
    input  logic            fault,
    output int              errors
);
    import ldst_pkg::*;

    localparam int IDX_W = $clog2(MEM_WORDS);
    localparam logic [31:0] MEM_LIMIT = MEM_BASE + 32'(MEM_WORDS * 4);

    logic [31:0]      shadow [MEM_WORDS];
    logic             pend;
    logic             p_rd;
    logic             p_sign;
    size_e            p_size;
    logic [31:0]      p_addr;
    logic [31:0]      p_wdata;
    logic [31:0]      last_mtime;
    logic             have_mtime;
    logic [31:0]      off_w;
    logic [IDX_W-1:0] idx;
    logic [31:0]      exp_data;
    logic             exp_fault;
    string            name;

    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[i] = 32'd0;
        end
    end

    function automatic logic in_sram(input logic [31:0] a);
        return a >= MEM_BASE && a < MEM_LIMIT;
    endfunction

    function automatic logic in_clint(input logic [31:0] a);
        return a >= 32'h0200_0048 && a <= 32'h0200_004F;
    endfunction

    // sram never faults, clint only on writes, anything else always
    function automatic logic ref_fault(input logic rd, input logic [31:0] a);
        if (in_sram(a)) begin
            return 1'b0;
        end
        if (in_clint(a)) begin
            return !rd;
        end
        return 1'b1;
    endfunction

    // expected load result from the stored word
    function automatic logic [31:0] ref_load(input logic [31:0] word, input size_e sz,
                                             input logic [1:0] off, input logic sgn);
        logic [7:0]  b;
        logic [15:0] h;
        b = word[8*off +: 8];
        h = off[1] ? word[31:16] : word[15:0];
        case (sz)
            SZ_BYTE: return {{24{sgn & b[7]}}, b};
            SZ_HALF: return {{16{sgn & h[15]}}, h};
            SZ_WORD: return word;
            default: return 32'd0;
        endcase
    endfunction

    // low data bytes land on the addressed lanes
    function automatic logic [31:0] ref_store(input logic [31:0] word, input size_e sz,
                                              input logic [1:0] off, input logic [31:0] d);
        logic [31:0] res;
        res = word;
        case (sz)
            SZ_BYTE: res[8*off +: 8] = d[7:0];
            SZ_HALF: begin
                if (off[1]) begin
                    res[31:16] = d[15:0];
                end else begin
                    res[15:0] = d[15:0];
                end
            end
            SZ_WORD: res = d;
            default: ;
        endcase
        return res;
    endfunction

    always @(posedge clk) begin
        if (!rst_n) begin
            errors     = 0;
            pend       = 1'b0;
            have_mtime = 1'b0;
        end else begin
            if (valid && pend) begin
                off_w     = p_addr - MEM_BASE;
                idx       = off_w[IDX_W+1:2];
                exp_fault = ref_fault(p_rd, p_addr);
                name      = in_sram(p_addr) ? "sram" : (in_clint(p_addr) ? "clint" : "unmapped");
                name      = {name, p_rd ? "_load" : "_store"};
                if (fault !== exp_fault) begin
                    $display("Fail %s fault addr=%08h expected=%0d actual=%0d",
                             name, p_addr, exp_fault, fault);
                    errors++;
                end
                if (p_rd && in_sram(p_addr)) begin
                    exp_data = ref_load(shadow[idx], p_size, p_addr[1:0], p_sign);
                    if (rdata !== exp_data) begin
                        $display("Fail %s addr=%08h expected=%08h actual=%08h",
                                 name, p_addr, exp_data, rdata);
                        errors++;
                    end
                end else if (p_rd && in_clint(p_addr) && p_addr[2]) begin
                    // high word stays zero this early
                    if (rdata !== 32'd0) begin
                        $display("Fail %s addr=%08h expected=%08h actual=%08h",
                                 name, p_addr, 32'd0, rdata);
                        errors++;
                    end
                end else if (p_rd && in_clint(p_addr)) begin
                    if (have_mtime && rdata <= last_mtime) begin
                        $display("Fail %s addr=%08h expected=above %08h actual=%08h",
                                 name, p_addr, last_mtime, rdata);
                        errors++;
                    end
                    last_mtime = rdata;
                    have_mtime = 1'b1;
                end
                if (!p_rd && in_sram(p_addr)) begin
                    shadow[idx] = ref_store(shadow[idx], p_size, p_addr[1:0], p_wdata);
                end
                pend = 1'b0;
            end else if (valid && !(ready && !ren && !wen)) begin
                $display("valid pulse seen with no access in progress");
                errors++;
            end
            if (ready && !ren && !wen) begin
                if (valid !== 1'b1 || fault !== 1'b0) begin
                    $display("Fail noop valid/fault expected=1/0 actual=%0d/%0d", valid, fault);
                    errors++;
                end
            end else if (ready) begin
                pend    = 1'b1;
                p_rd    = ren;
                p_sign  = sign;
                p_size  = size;
                p_addr  = addr;
                p_wdata = wdata;
            end
        end
    end

endmodule

`default_nettype wire

// File: bench/ldst_props.sv
`timescale 1ns/1ps
`default_nettype none

module ldst_props (
    input logic clk,
    input logic rst_n,
    input logic ar_valid,
    input logic ar_ready,
    input logic aw_valid,
    input logic aw_ready,
    input logic w_valid,
    input logic mem_valid
);

    // address valids stay up until accepted
    ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ar_valid && !ar_ready |=> ar_valid)
        else $error("ar_valid dropped before ar_ready");

    aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
        aw_valid && !aw_ready |=> aw_valid)
        else $error("aw_valid dropped before aw_ready");

    // write data only after the address went through
    w_after_aw: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(w_valid) |-> $past(aw_valid && aw_ready))
        else $error("w_valid rose before the aw transfer");

    // completion pulse of a memory access, ahead of the pass-through mux
    valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        mem_valid |=> !mem_valid)
        else $error("valid high two cycles in a row on a memory access");

endmodule

bind ldst_lsu ldst_props u_props (
    .clk      (clk),
    .rst_n    (rst_n),
    .ar_valid (ar_valid),
    .ar_ready (ar_ready),
    .aw_valid (aw_valid),
    .aw_ready (aw_ready),
    .w_valid  (w_valid),
    .mem_valid(valid_q)
);

`default_nettype wire

// File: bench/tb_ldst_sys.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ldst_sys;
    import ldst_pkg::*;

    localparam int MEM_WORDS = 256;
    localparam int TIMEOUT   = 50;

    logic        clk;
    logic        rst_n;
    logic        ready;
    logic        ren;
    logic        wen;
    logic        sign;
    size_e       size;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic        valid;
    logic        fault;
    int          chk_errors;
    int          timeouts;
    logic [31:0] rng;
    logic [31:0] word_addr [8];
    logic [31:0] base;
    logic [31:0] r;
    logic [31:0] d;

    ldst_sys #(
        .MEM_WORDS(MEM_WORDS)
    ) u_ldst_sys (
        .clk  (clk),
        .rst_n(rst_n),
        .ready(ready),
        .ren  (ren),
        .wen  (wen),
        .sign (sign),
        .size (size),
        .addr (addr),
        .wdata(wdata),
        .rdata(rdata),
        .valid(valid),
        .fault(fault)
    );

    ldst_checker #(
        .MEM_WORDS(MEM_WORDS)
    ) u_checker (
        .clk   (clk),
        .rst_n (rst_n),
        .ready (ready),
        .ren   (ren),
        .wen   (wen),
        .sign  (sign),
        .size  (size),
        .addr  (addr),
        .wdata (wdata),
        .rdata (rdata),
        .valid (valid),
        .fault (fault),
        .errors(chk_errors)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] v;
        v = x ^ (x << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    task automatic next_rand(output logic [31:0] v);
        rng = xorshift32(rng);
        v   = rng;
    endtask

    // one ready strobe, then wait for valid
    task automatic access(input logic rd, input logic wr, input logic sgn, input size_e sz,
                          input logic [31:0] a, input logic [31:0] dat);
        int   cycles;
        logic got;
        @(posedge clk);
        #1;
        ren   = rd;
        wen   = wr;
        sign  = sgn;
        size  = sz;
        addr  = a;
        wdata = dat;
        ready = 1'b1;
        cycles = 0;
        got    = 1'b0;
        while (!got && cycles < TIMEOUT) begin
            @(negedge clk);
            got = valid;
            @(posedge clk);
            #1;
            ready = 1'b0;
            cycles++;
        end
        ren = 1'b0;
        wen = 1'b0;
        if (!got) begin
            $display("timeout: no valid within %0d cycles for access at %08h", TIMEOUT, a);
            timeouts++;
        end
    endtask

    task automatic store(input size_e sz, input logic [31:0] a, input logic [31:0] dat);
        access(1'b0, 1'b1, 1'b0, sz, a, dat);
    endtask

    task automatic load(input size_e sz, input logic sgn, input logic [31:0] a);
        access(1'b1, 1'b0, sgn, sz, a, 32'd0);
    endtask

    initial begin
        rst_n    = 1'b0;
        ready    = 1'b0;
        ren      = 1'b0;
        wen      = 1'b0;
        sign     = 1'b0;
        size     = SZ_NONE;
        addr     = 32'd0;
        wdata    = 32'd0;
        rng      = 32'd59;
        timeouts = 0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // word writes, then read back
        for (int i = 0; i < 8; i++) begin
            next_rand(r);
            next_rand(d);
            word_addr[i] = MEM_BASE + {22'd0, r[7:0], 2'b00};
            store(SZ_WORD, word_addr[i], d);
        end
        for (int i = 0; i < 8; i++) begin
            load(SZ_WORD, 1'b0, word_addr[i]);
        end

        // narrow stores on every lane
        for (int i = 0; i < 4; i++) begin
            next_rand(r);
            base = MEM_BASE + {22'd0, r[7:0], 2'b00};
            for (int off = 0; off < 4; off++) begin
                next_rand(d);
                store(SZ_BYTE, base + 32'(off), d);
                load(SZ_WORD, 1'b0, base);
            end
            for (int off = 0; off < 4; off += 2) begin
                next_rand(d);
                store(SZ_HALF, base + 32'(off), d);
                load(SZ_WORD, 1'b0, base);
            end
        end

        // narrow loads with both sign settings
        store(SZ_WORD, MEM_BASE + 32'h10, 32'h8f7e_f001);
        word_addr[0] = MEM_BASE + 32'h10;
        for (int i = 0; i < 4; i++) begin
            for (int off = 0; off < 4; off++) begin
                load(SZ_BYTE, 1'b0, word_addr[i] + 32'(off));
                load(SZ_BYTE, 1'b1, word_addr[i] + 32'(off));
            end
            for (int off = 0; off < 4; off += 2) begin
                load(SZ_HALF, 1'b0, word_addr[i] + 32'(off));
                load(SZ_HALF, 1'b1, word_addr[i] + 32'(off));
            end
        end

        // mtime low then high
        load(SZ_WORD, 1'b0, 32'h0200_0048);
        load(SZ_WORD, 1'b0, 32'h0200_0048);
        load(SZ_WORD, 1'b0, 32'h0200_004C);

        // faulting accesses, sram must stay intact
        next_rand(d);
        store(SZ_WORD, 32'h0200_0048, d);
        load(SZ_WORD, 1'b0, 32'h1000_0000);
        store(SZ_WORD, 32'h1000_0000, d);
        store(SZ_WORD, MEM_BASE + 32'(MEM_WORDS * 4), d);
        load(SZ_WORD, 1'b0, MEM_BASE + 32'(MEM_WORDS * 4));
        load(SZ_WORD, 1'b0, MEM_BASE);
        for (int i = 0; i < 8; i++) begin
            load(SZ_WORD, 1'b0, word_addr[i]);
        end

        // strobes with no memory op
        repeat (3) access(1'b0, 1'b0, 1'b0, SZ_NONE, 32'd0, 32'd0);

        repeat (4) @(posedge clk);
        $display("checks done: %0d checker errors, %0d timeouts", chk_errors, timeouts);
        if (chk_errors == 0 && timeouts == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: design/ldst_addr_dec.sv
`timescale 1ns/1ps
`default_nettype none

module ldst_addr_dec #(
    parameter int MEM_WORDS = 1024
) (
    input  logic               clk,
    input  logic               rst_n,
    // upstream, facing the LSU
    input  logic               ar_valid,
    input  ldst_pkg::ar_chan_t ar,
    output logic               ar_ready,
    input  logic               aw_valid,
    input  ldst_pkg::aw_chan_t aw,
    output logic               aw_ready,
    input  logic               w_valid,
    input  ldst_pkg::w_chan_t  w,
    output logic               w_ready,
    output logic               r_valid,
    output ldst_pkg::r_chan_t  r,
    input  logic               r_ready,
    output logic               b_valid,
    output ldst_pkg::b_chan_t  b,
    input  logic               b_ready,
    // SRAM slave
    output logic               mem_ar_valid,
    output ldst_pkg::ar_chan_t mem_ar,
    input  logic               mem_ar_ready,
    output logic               mem_aw_valid,
    output ldst_pkg::aw_chan_t mem_aw,
    input  logic               mem_aw_ready,
    output logic               mem_w_valid,
    output ldst_pkg::w_chan_t  mem_w,
    input  logic               mem_w_ready,
    input  logic               mem_r_valid,
    input  ldst_pkg::r_chan_t  mem_r,
    output logic               mem_r_ready,
    input  logic               mem_b_valid,
    input  ldst_pkg::b_chan_t  mem_b,
    output logic               mem_b_ready,
    // CLINT slave
    output logic               clint_ar_valid,
    output ldst_pkg::ar_chan_t clint_ar,
    input  logic               clint_ar_ready,
    output logic               clint_aw_valid,
    output ldst_pkg::aw_chan_t clint_aw,
    input  logic               clint_aw_ready,
    output logic               clint_w_valid,
    output ldst_pkg::w_chan_t  clint_w,
    input  logic               clint_w_ready,
    input  logic               clint_r_valid,
    input  ldst_pkg::r_chan_t  clint_r,
    output logic               clint_r_ready,
    input  logic               clint_b_valid,
    input  ldst_pkg::b_chan_t  clint_b,
    output logic               clint_b_ready
);
    import ldst_pkg::*;

    typedef enum logic [1:0] {
        TGT_NONE  = 2'd0,
        TGT_MEM   = 2'd1,
        TGT_CLINT = 2'd2,
        TGT_ERR   = 2'd3
    } target_e;

    localparam logic [31:0] MEM_END = MEM_BASE + 32'(MEM_WORDS * 4) - 32'd1;

    target_e     route_q;
    target_e     dec_tgt;
    target_e     cur;
    logic [31:0] dec_addr;
    logic        addr_xfer;
    logic        resp_xfer;
    logic        err_r_valid;
    logic        err_w_pend;
    logic        err_b_valid;

    // only one of ar/aw is ever pending
    assign dec_addr = ar_valid ? ar.addr : aw.addr;

    always_comb begin
        if (dec_addr >= CLINT_BASE && dec_addr <= CLINT_END) begin
            dec_tgt = TGT_CLINT;
        end else if (dec_addr >= MEM_BASE && dec_addr <= MEM_END) begin
            dec_tgt = TGT_MEM;
        end else begin
            dec_tgt = TGT_ERR;
        end
    end

    // latched route wins once the address is accepted
    assign cur = (route_q != TGT_NONE) ? route_q : dec_tgt;

    assign addr_xfer = (ar_valid && ar_ready) || (aw_valid && aw_ready);
    assign resp_xfer = (r_valid && r_ready) || (b_valid && b_ready);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            route_q <= TGT_NONE;
        end else if (resp_xfer) begin
            route_q <= TGT_NONE;
        end else if (addr_xfer) begin
            route_q <= dec_tgt;
        end
    end

    // built-in responder for unmapped addresses
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            err_r_valid <= 1'b0;
            err_w_pend  <= 1'b0;
            err_b_valid <= 1'b0;
        end else begin
            if (cur == TGT_ERR && ar_valid && ar_ready) begin
                err_r_valid <= 1'b1;
            end else if (err_r_valid && r_ready) begin
                err_r_valid <= 1'b0;
            end
            if (cur == TGT_ERR && aw_valid && aw_ready) begin
                err_w_pend <= 1'b1;
            end else if (err_w_pend && w_valid) begin
                err_w_pend  <= 1'b0;
                err_b_valid <= 1'b1;
            end else if (err_b_valid && b_ready) begin
                err_b_valid <= 1'b0;
            end
        end
    end

    // requests go to the selected slave only
    assign mem_ar_valid   = ar_valid && (cur == TGT_MEM);
    assign mem_aw_valid   = aw_valid && (cur == TGT_MEM);
    assign mem_w_valid    = w_valid && (cur == TGT_MEM);
    assign mem_r_ready    = r_ready && (cur == TGT_MEM);
    assign mem_b_ready    = b_ready && (cur == TGT_MEM);
    assign clint_ar_valid = ar_valid && (cur == TGT_CLINT);
    assign clint_aw_valid = aw_valid && (cur == TGT_CLINT);
    assign clint_w_valid  = w_valid && (cur == TGT_CLINT);
    assign clint_r_ready  = r_ready && (cur == TGT_CLINT);
    assign clint_b_ready  = b_ready && (cur == TGT_CLINT);

    assign mem_ar   = ar;
    assign mem_aw   = aw;
    assign mem_w    = w;
    assign clint_ar = ar;
    assign clint_aw = aw;
    assign clint_w  = w;

    always_comb begin
        ar_ready = 1'b0;
        aw_ready = 1'b0;
        w_ready  = 1'b0;
        r_valid  = 1'b0;
        r        = '0;
        b_valid  = 1'b0;
        b        = '0;
        case (cur)
            TGT_MEM: begin
                ar_ready = mem_ar_ready;
                aw_ready = mem_aw_ready;
                w_ready  = mem_w_ready;
                r_valid  = mem_r_valid;
                r        = mem_r;
                b_valid  = mem_b_valid;
                b        = mem_b;
            end
            TGT_CLINT: begin
                ar_ready = clint_ar_ready;
                aw_ready = clint_aw_ready;
                w_ready  = clint_w_ready;
                r_valid  = clint_r_valid;
                r        = clint_r;
                b_valid  = clint_b_valid;
                b        = clint_b;
            end
            TGT_ERR: begin
                ar_ready = !err_r_valid;
                aw_ready = !err_w_pend && !err_b_valid;
                w_ready  = err_w_pend;
                r_valid  = err_r_valid;
                r        = '{data: 32'd0, resp: RESP_DECERR};
                b_valid  = err_b_valid;
                b        = '{resp: RESP_DECERR};
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: design/ldst_clint.sv
`timescale 1ns/1ps
`default_nettype none

module ldst_clint (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               ar_valid,
    input  ldst_pkg::ar_chan_t ar,
    output logic               ar_ready,
    output logic               r_valid,
    output ldst_pkg::r_chan_t  r,
    input  logic               r_ready,
    input  logic               aw_valid,
    input  ldst_pkg::aw_chan_t aw,
    output logic               aw_ready,
    input  logic               w_valid,
    input  ldst_pkg::w_chan_t  w,
    output logic               w_ready,
    output logic               b_valid,
    output ldst_pkg::b_chan_t  b,
    input  logic               b_ready
);
    import ldst_pkg::*;

    logic [63:0] mtime;
    logic [31:0] r_data_q;
    logic        aw_done;

    // free-running, never written from the bus
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtime <= 64'd0;
        end else begin
            mtime <= mtime + 64'd1;
        end
    end

    assign ar_ready = !r_valid;
    assign aw_ready = !aw_done && !b_valid;
    assign w_ready  = aw_done;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            r_valid <= 1'b0;
            aw_done <= 1'b0;
            b_valid <= 1'b0;
        end else begin
            if (ar_valid && ar_ready) begin
                r_valid <= 1'b1;
            end else if (r_ready) begin
                r_valid <= 1'b0;
            end
            if (aw_valid && aw_ready) begin
                aw_done <= 1'b1;
            end else if (w_valid && w_ready) begin
                aw_done <= 1'b0;
                b_valid <= 1'b1;
            end else if (b_ready) begin
                b_valid <= 1'b0;
            end
        end
    end

    // bit 2 picks 0x4c, the high word
    always_ff @(posedge clk) begin
        if (ar_valid && ar_ready) begin
            r_data_q <= ar.addr[2] ? mtime[63:32] : mtime[31:0];
        end
    end

    assign r = '{data: r_data_q, resp: RESP_OKAY};
    // mtime is read-only here
    assign b = '{resp: RESP_SLVERR};

endmodule

`default_nettype wire

// File: design/ldst_lsu.sv
`timescale 1ns/1ps
`default_nettype none

module ldst_lsu (
    input  logic               clk,
    input  logic               rst_n,
    // pipeline side
    input  logic               ready,
    input  logic               ren,
    input  logic               wen,
    input  logic               sign,
    input  ldst_pkg::size_e    size,
    input  logic [31:0]        addr,
    input  logic [31:0]        wdata,
    output logic [31:0]        rdata,
    output logic               valid,
    output logic               fault,
    // bus side
    output logic               ar_valid,
    output ldst_pkg::ar_chan_t ar,
    input  logic               ar_ready,
    output logic               aw_valid,
    output ldst_pkg::aw_chan_t aw,
    input  logic               aw_ready,
    output logic               w_valid,
    output ldst_pkg::w_chan_t  w,
    input  logic               w_ready,
    input  logic               r_valid,
    input  ldst_pkg::r_chan_t  r,
    output logic               r_ready,
    input  logic               b_valid,
    input  ldst_pkg::b_chan_t  b,
    output logic               b_ready
);
    import ldst_pkg::*;

    lsu_state_e  state_q;
    lsu_state_e  state_d;
    logic [4:0]  lane_shift;
    logic [3:0]  strb;
    logic [31:0] load_shifted;
    logic [31:0] load_value;
    logic        r_xfer;
    logic        b_xfer;
    logic        valid_q;
    logic        fault_q;

    // responses are never stalled
    assign r_ready = 1'b1;
    assign b_ready = 1'b1;

    assign r_xfer = (state_q == ST_R) && r_valid && r_ready;
    assign b_xfer = (state_q == ST_B) && b_valid && b_ready;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (ready && ren) begin
                    state_d = ST_AR;
                end else if (ready && wen) begin
                    state_d = ST_AW;
                end
            end
            ST_AR: if (ar_ready) state_d = ST_R;
            ST_R:  if (r_xfer) state_d = ST_IDLE;
            ST_AW: if (aw_ready) state_d = ST_W;
            ST_W:  if (w_ready) state_d = ST_B;
            ST_B:  if (b_xfer) state_d = ST_IDLE;
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
            valid_q <= 1'b0;
            fault_q <= 1'b0;
        end else begin
            state_q <= state_d;
            valid_q <= r_xfer || b_xfer;
            fault_q <= (r_xfer && r.resp != RESP_OKAY) || (b_xfer && b.resp != RESP_OKAY);
        end
    end

    // channel valids straight from the state register
    assign ar_valid = (state_q == ST_AR);
    assign aw_valid = (state_q == ST_AW);
    assign w_valid  = (state_q == ST_W);

    // pipeline holds addr and size until valid
    assign ar = '{addr: addr, size: size};
    assign aw = '{addr: addr, size: size};

    assign lane_shift = {addr[1:0], 3'b000};

    always_comb begin
        case (size)
            SZ_BYTE: strb = 4'b0001 << addr[1:0];
            SZ_HALF: strb = addr[1] ? 4'b1100 : 4'b0011;
            SZ_WORD: strb = 4'b1111;
            default: strb = 4'b0000;
        endcase
    end

    assign w = '{data: wdata << lane_shift, strb: strb};

    // load extraction, byte lane down to bit 0 then extend
    assign load_shifted = r.data >> lane_shift;

    always_comb begin
        case (size)
            SZ_BYTE: load_value = {{24{sign && load_shifted[7]}}, load_shifted[7:0]};
            SZ_HALF: load_value = {{16{sign && load_shifted[15]}}, load_shifted[15:0]};
            SZ_WORD: load_value = load_shifted;
            default: load_value = 32'd0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdata <= 32'd0;
        end else if (r_xfer) begin
            rdata <= load_value;
        end
    end

    // no memory op means valid just mirrors the strobe
    assign valid = (ren || wen) ? valid_q : ready;
    assign fault = (ren || wen) && fault_q;

endmodule

`default_nettype wire

// File: design/ldst_pkg.sv
`default_nettype none

package ldst_pkg;

    // access width, same coding as the pipeline mask
    typedef enum logic [1:0] {
        SZ_NONE = 2'd0,
        SZ_BYTE = 2'd1,
        SZ_HALF = 2'd2,
        SZ_WORD = 2'd3
    } size_e;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'd0,
        RESP_EXOKAY = 2'd1,
        RESP_SLVERR = 2'd2,
        RESP_DECERR = 2'd3
    } resp_e;

    typedef enum logic [2:0] {
        ST_IDLE = 3'd0,
        ST_AR   = 3'd1,
        ST_R    = 3'd2,
        ST_AW   = 3'd3,
        ST_W    = 3'd4,
        ST_B    = 3'd5
    } lsu_state_e;

    // single-beat channel payloads
    typedef struct packed {
        logic [31:0] addr;
        size_e       size;
    } ar_chan_t;

    typedef struct packed {
        logic [31:0] addr;
        size_e       size;
    } aw_chan_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
    } w_chan_t;

    typedef struct packed {
        logic [31:0] data;
        resp_e       resp;
    } r_chan_t;

    typedef struct packed {
        resp_e resp;
    } b_chan_t;

    // mtime window, low word at 0x48 and high word at 0x4c
    localparam logic [31:0] CLINT_BASE = 32'h0200_0048;
    localparam logic [31:0] CLINT_END  = 32'h0200_004F;
    localparam logic [31:0] MEM_BASE   = 32'h8000_0000;

endpackage

`default_nettype wire

// File: design/ldst_sram.sv
`timescale 1ns/1ps
`default_nettype none

module ldst_sram #(
    parameter int MEM_WORDS = 1024
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               ar_valid,
    input  ldst_pkg::ar_chan_t ar,
    output logic               ar_ready,
    output logic               r_valid,
    output ldst_pkg::r_chan_t  r,
    input  logic               r_ready,
    input  logic               aw_valid,
    input  ldst_pkg::aw_chan_t aw,
    output logic               aw_ready,
    input  logic               w_valid,
    input  ldst_pkg::w_chan_t  w,
    output logic               w_ready,
    output logic               b_valid,
    output ldst_pkg::b_chan_t  b,
    input  logic               b_ready
);
    import ldst_pkg::*;

    localparam int IDX_W = $clog2(MEM_WORDS);

    logic [31:0]      mem [MEM_WORDS];
    logic [31:0]      r_data_q;
    logic [31:0]      r_off;
    logic [31:0]      aw_off;
    logic [IDX_W-1:0] w_idx_q;
    logic             aw_done;

    // byte offsets into the array
    assign r_off  = ar.addr - MEM_BASE;
    assign aw_off = aw.addr - MEM_BASE;

    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = 32'd0;
        end
    end

    // stall new reads while a response is waiting
    assign ar_ready = !r_valid;
    assign aw_ready = !aw_done && !b_valid;
    assign w_ready  = aw_done;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            r_valid <= 1'b0;
            aw_done <= 1'b0;
            b_valid <= 1'b0;
        end else begin
            if (ar_valid && ar_ready) begin
                r_valid <= 1'b1;
            end else if (r_ready) begin
                r_valid <= 1'b0;
            end
            if (aw_valid && aw_ready) begin
                aw_done <= 1'b1;
            end else if (w_valid && w_ready) begin
                aw_done <= 1'b0;
                b_valid <= 1'b1;
            end else if (b_ready) begin
                b_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ar_valid && ar_ready) begin
            r_data_q <= mem[r_off[IDX_W+1:2]];
        end
        if (aw_valid && aw_ready) begin
            w_idx_q <= aw_off[IDX_W+1:2];
        end
    end

    // strobed byte writes
    always @(posedge clk) begin
        if (w_valid && w_ready) begin
            for (int i = 0; i < 4; i++) begin
                if (w.strb[i]) begin
                    mem[w_idx_q][8*i +: 8] <= w.data[8*i +: 8];
                end
            end
        end
    end

    assign r = '{data: r_data_q, resp: RESP_OKAY};
    assign b = '{resp: RESP_OKAY};

endmodule

`default_nettype wire

// File: design/ldst_sys.sv
`timescale 1ns/1ps
`default_nettype none

module ldst_sys #(
    parameter int MEM_WORDS = 1024
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            ready,
    input  logic            ren,
    input  logic            wen,
    input  logic            sign,
    input  ldst_pkg::size_e size,
    input  logic [31:0]     addr,
    input  logic [31:0]     wdata,
    output logic [31:0]     rdata,
    output logic            valid,
    output logic            fault
);
    import ldst_pkg::*;

    // LSU to decoder, names match both port lists
    logic     ar_valid, ar_ready, aw_valid, aw_ready, w_valid, w_ready;
    logic     r_valid, r_ready, b_valid, b_ready;
    ar_chan_t ar;
    aw_chan_t aw;
    w_chan_t  w;
    r_chan_t  r;
    b_chan_t  b;

    // decoder to SRAM
    logic     mem_ar_valid, mem_ar_ready, mem_aw_valid, mem_aw_ready;
    logic     mem_w_valid, mem_w_ready, mem_r_valid, mem_r_ready;
    logic     mem_b_valid, mem_b_ready;
    ar_chan_t mem_ar;
    aw_chan_t mem_aw;
    w_chan_t  mem_w;
    r_chan_t  mem_r;
    b_chan_t  mem_b;

    // decoder to CLINT
    logic     clint_ar_valid, clint_ar_ready, clint_aw_valid, clint_aw_ready;
    logic     clint_w_valid, clint_w_ready, clint_r_valid, clint_r_ready;
    logic     clint_b_valid, clint_b_ready;
    ar_chan_t clint_ar;
    aw_chan_t clint_aw;
    w_chan_t  clint_w;
    r_chan_t  clint_r;
    b_chan_t  clint_b;

    ldst_lsu u_lsu (.*);

    ldst_addr_dec #(
        .MEM_WORDS(MEM_WORDS)
    ) u_dec (.*);

    ldst_sram #(
        .MEM_WORDS(MEM_WORDS)
    ) u_sram (
        .clk     (clk),
        .rst_n   (rst_n),
        .ar_valid(mem_ar_valid),
        .ar      (mem_ar),
        .ar_ready(mem_ar_ready),
        .r_valid (mem_r_valid),
        .r       (mem_r),
        .r_ready (mem_r_ready),
        .aw_valid(mem_aw_valid),
        .aw      (mem_aw),
        .aw_ready(mem_aw_ready),
        .w_valid (mem_w_valid),
        .w       (mem_w),
        .w_ready (mem_w_ready),
        .b_valid (mem_b_valid),
        .b       (mem_b),
        .b_ready (mem_b_ready)
    );

    ldst_clint u_clint (
        .clk     (clk),
        .rst_n   (rst_n),
        .ar_valid(clint_ar_valid),
        .ar      (clint_ar),
        .ar_ready(clint_ar_ready),
        .r_valid (clint_r_valid),
        .r       (clint_r),
        .r_ready (clint_r_ready),
        .aw_valid(clint_aw_valid),
        .aw      (clint_aw),
        .aw_ready(clint_aw_ready),
        .w_valid (clint_w_valid),
        .w       (clint_w),
        .w_ready (clint_w_ready),
        .b_valid (clint_b_valid),
        .b       (clint_b),
        .b_ready (clint_b_ready)
    );

endmodule

`default_nettype wire

// File: ldst_sys.f
design/ldst_pkg.sv
design/ldst_lsu.sv
design/ldst_addr_dec.sv
design/ldst_clint.sv
design/ldst_sram.sv
design/ldst_sys.sv
bench/ldst_props.sv
bench/ldst_checker.sv
bench/tb_ldst_sys.sv

// File: run_sim.sh
#!/bin/sh
# build and run the ldst_sys testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_ldst_sys -f ldst_sys.f -o sim_ldst_sys
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_ldst_sys > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Result: FAILED" "$LOG"; then
    exit 1
fi
if ! grep -q "Result: PASSED" "$LOG"; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0
